// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_exec_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: common/exec_types_pkg.sv
`default_nettype none

package exec_types_pkg;

    // upstream sequence number width
    localparam int unsigned TAG_W = 4;

    // instruction as delivered by the issue port
    typedef struct packed {
        logic [rv32_isa_pkg::ILEN-1:0] instr;
        logic [rv32_isa_pkg::XLEN-1:0] rs1_val;
        logic [rv32_isa_pkg::XLEN-1:0] rs2_val;
        logic [TAG_W-1:0]              tag;
    } issue_req_t;

    // decoded operation, ready for the alu
    typedef struct packed {
        rv32_isa_pkg::alu_sel_e         sel;
        logic [rv32_isa_pkg::XLEN-1:0]  op1;
        logic [rv32_isa_pkg::XLEN-1:0]  op2;
        logic [rv32_isa_pkg::REG_W-1:0] rd;
        logic [TAG_W-1:0]               tag;
        logic                           illegal;
    } alu_op_t;

    // writeback result returned on the output port
    typedef struct packed {
        logic [rv32_isa_pkg::REG_W-1:0] rd;
        logic [TAG_W-1:0]               tag;
        logic                           illegal;
        logic [rv32_isa_pkg::XLEN-1:0]  value;
    } wb_result_t;

endpackage

`default_nettype wire

// File: common/rv32_isa_pkg.sv
`default_nettype none

package rv32_isa_pkg;

    // word width of the integer datapath
    localparam int unsigned XLEN = 32;
    // instruction word width
    localparam int unsigned ILEN = 32;
    // register index width, 32 architectural registers
    localparam int unsigned REG_W = 5;
    // RV32 shifts only look at the low five bits of the amount
    localparam int unsigned SHAMT_W = 5;

    // major opcodes handled by this slice
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3 codes, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 bit that selects SUB / SRA (instruction bit 30)
    localparam int unsigned F7_ALT_BIT = 5;

    // alu selection, encoding kept from the existing alu block
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SLL    = 4'd1,
        ALU_SLT    = 4'd2,
        ALU_SLTU   = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SRL    = 4'd5,
        ALU_OR     = 4'd6,
        ALU_AND    = 4'd7,
        ALU_SUB    = 4'd8,
        // result is operand b unchanged, used for LUI
        ALU_PASS_B = 4'd9,
        ALU_SRA    = 4'd13
    } alu_sel_e;

endpackage

`default_nettype wire

// File: decode/instr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_req,
    input  exec_types_pkg::issue_req_t in_data,
    output logic                       in_ack,
    input  logic                       op_full,
    output logic                       op_push,
    output exec_types_pkg::alu_op_t    op_data
);

    import rv32_isa_pkg::*;
    import exec_types_pkg::*;

    // instruction fields
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [REG_W-1:0] rd;
    logic             alt;
    // immediates
    logic [XLEN-1:0]  imm_i;
    logic [XLEN-1:0]  imm_u;

    // funct3 to alu selection, shared by the register and immediate forms
    function automatic alu_sel_e f3_to_sel(
        input logic [2:0] f3,
        input logic       alt_bit,
        input logic       reg_form
    );
        alu_sel_e sel;
        case (f3)
            // there is no SUBI, bit 30 is part of the immediate there
            F3_ADD_SUB: sel = (alt_bit && reg_form) ? ALU_SUB : ALU_ADD;
            F3_SLL:     sel = ALU_SLL;
            F3_SLT:     sel = ALU_SLT;
            F3_SLTU:    sel = ALU_SLTU;
            F3_XOR:     sel = ALU_XOR;
            // SRA and SRAI both carry bit 30
            F3_SRL_SRA: sel = alt_bit ? ALU_SRA : ALU_SRL;
            F3_OR:      sel = ALU_OR;
            F3_AND:     sel = ALU_AND;
            default:    sel = ALU_ADD;
        endcase
        return sel;
    endfunction

    assign opcode = in_data.instr[6:0];
    assign rd     = in_data.instr[11:7];
    assign funct3 = in_data.instr[14:12];
    assign funct7 = in_data.instr[31:25];
    assign alt    = funct7[F7_ALT_BIT];

    // I-type, sign extended from bit 31
    assign imm_i = {{(XLEN-12){in_data.instr[31]}}, in_data.instr[31:20]};
    // U-type, low 12 bits zero
    assign imm_u = {in_data.instr[31:12], 12'b0};

    always_comb begin
        op_data.sel     = ALU_PASS_B;
        op_data.op1     = in_data.rs1_val;
        op_data.op2     = in_data.rs2_val;
        op_data.rd      = rd;
        op_data.tag     = in_data.tag;
        op_data.illegal = 1'b0;
        case (opcode)
            OPC_OP: begin
                op_data.sel = f3_to_sel(funct3, alt, 1'b1);
            end
            OPC_OP_IMM: begin
                op_data.sel = f3_to_sel(funct3, alt, 1'b0);
                // shamt sits in the low immediate bits
                op_data.op2 = imm_i;
            end
            OPC_LUI: begin
                op_data.sel = ALU_PASS_B;
                op_data.op2 = imm_u;
            end
            default: begin
                // unsupported, pass b = 0 gives value 0
                op_data.op2     = '0;
                op_data.illegal = 1'b1;
            end
        endcase
    end

    // capture on a fresh request when the op fifo has room
    assign op_push = in_req && !in_ack && !op_full;

    // four-phase receive, ack follows the request low
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_ack <= 1'b0;
        end else if (op_push) begin
            in_ack <= 1'b1;
        end else if (in_ack && !in_req) begin
            in_ack <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: execute/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  logic [rv32_isa_pkg::XLEN-1:0] op1,
    input  logic [rv32_isa_pkg::XLEN-1:0] op2,
    input  rv32_isa_pkg::alu_sel_e        sel,
    output logic [rv32_isa_pkg::XLEN-1:0] res
);

    import rv32_isa_pkg::*;

    // shift amount, upper bits of op2 ignored
    logic [SHAMT_W-1:0] shamt;
    // compare results
    logic               lt_s;
    logic               lt_u;

    assign shamt = op2[SHAMT_W-1:0];
    assign lt_s  = $signed(op1) < $signed(op2);
    assign lt_u  = op1 < op2;

    always_comb begin
        case (sel)
            ALU_ADD:    res = op1 + op2;
            ALU_SUB:    res = op1 - op2;
            // set-less-than gives 0 or 1
            ALU_SLT:    res = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:   res = {{(XLEN-1){1'b0}}, lt_u};
            ALU_XOR:    res = op1 ^ op2;
            ALU_OR:     res = op1 | op2;
            ALU_AND:    res = op1 & op2;
            ALU_SLL:    res = op1 << shamt;
            ALU_SRL:    res = op1 >> shamt;
            // arithmetic, sign bit fills from the left
            ALU_SRA:    res = $signed(op1) >>> shamt;
            ALU_PASS_B: res = op2;
            default:    res = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: execute/alu_exec.sv
`timescale 1ns/10ps
`default_nettype none

module alu_exec (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       op_empty,
    input  exec_types_pkg::alu_op_t    op_head,
    output logic                       op_pop,
    input  logic                       res_full,
    output logic                       res_push,
    output exec_types_pkg::wb_result_t res_data
);

    import rv32_isa_pkg::*;
    import exec_types_pkg::*;

    logic [XLEN-1:0] alu_res;
    // result register holds a value
    logic            res_valid;
    // stage moves when the result fifo has room
    logic            advance;

    alu alu0 (
        .op1 (op_head.op1),
        .op2 (op_head.op2),
        .sel (op_head.sel),
        .res (alu_res)
    );

    assign advance  = !res_full;
    assign op_pop   = advance && !op_empty;
    // push the held result while the next one is loaded
    assign res_push = advance && res_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (advance) begin
            res_valid <= op_pop;
        end
    end

    // payload register, loaded on each pop
    always_ff @(posedge clk) begin
        if (op_pop) begin
            res_data.rd      <= op_head.rd;
            res_data.tag     <= op_head.tag;
            res_data.illegal <= op_head.illegal;
            // illegal ops already select pass b with zero
            res_data.value   <= alu_res;
        end
    end

endmodule

`default_nettype wire

// File: sources.f
common/rv32_isa_pkg.sv
common/exec_types_pkg.sv
src/stream_fifo.sv
execute/alu.sv
execute/alu_exec.sv
decode/instr_decoder.sv
src/result_sender.sv
src/exec_top.sv
verif/exec_assertions.sv
verif/tb_exec_top.sv

// File: src/exec_top.sv
`timescale 1ns/10ps
`default_nettype none

module exec_top #(
    parameter int unsigned OP_DEPTH  = 4,
    parameter int unsigned RES_DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_req,
    input  exec_types_pkg::issue_req_t in_data,
    output logic                       in_ack,
    output logic                       out_req,
    output exec_types_pkg::wb_result_t out_data,
    input  logic                       out_ack
);

    import exec_types_pkg::*;

    // decoder to operation fifo
    logic       op_push;
    logic       op_full;
    alu_op_t    op_wdata;
    // operation fifo to execute stage
    logic       op_pop;
    logic       op_empty;
    alu_op_t    op_head;
    // execute stage to result fifo
    logic       res_push;
    logic       res_full;
    wb_result_t res_wdata;
    // result fifo to sender
    logic       res_pop;
    logic       res_empty;
    wb_result_t res_head;

    instr_decoder decoder0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_req  (in_req),
        .in_data (in_data),
        .in_ack  (in_ack),
        .op_full (op_full),
        .op_push (op_push),
        .op_data (op_wdata)
    );

    stream_fifo #(
        .payload_t (alu_op_t),
        .DEPTH     (OP_DEPTH)
    ) op_fifo0 (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (op_push),
        .wdata (op_wdata),
        .full  (op_full),
        .pop   (op_pop),
        .rdata (op_head),
        .empty (op_empty)
    );

    alu_exec exec0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .op_empty (op_empty),
        .op_head  (op_head),
        .op_pop   (op_pop),
        .res_full (res_full),
        .res_push (res_push),
        .res_data (res_wdata)
    );

    stream_fifo #(
        .payload_t (wb_result_t),
        .DEPTH     (RES_DEPTH)
    ) res_fifo0 (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (res_push),
        .wdata (res_wdata),
        .full  (res_full),
        .pop   (res_pop),
        .rdata (res_head),
        .empty (res_empty)
    );

    result_sender sender0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_empty (res_empty),
        .res_head  (res_head),
        .res_pop   (res_pop),
        .out_req   (out_req),
        .out_data  (out_data),
        .out_ack   (out_ack)
    );

endmodule

`default_nettype wire

// File: src/result_sender.sv
`timescale 1ns/10ps
`default_nettype none

module result_sender (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       res_empty,
    input  exec_types_pkg::wb_result_t res_head,
    output logic                       res_pop,
    output logic                       out_req,
    output exec_types_pkg::wb_result_t out_data,
    input  logic                       out_ack
);

    import exec_types_pkg::*;

    typedef enum logic {
        S_IDLE,
        S_SEND
    } state_e;

    state_e state;

    // req is high for the whole send state
    assign out_req = (state == S_SEND);
    // head leaves the fifo once the receiver has taken it
    assign res_pop = (state == S_SEND) && out_ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                // previous ack must be gone before a new req
                S_IDLE: if (!out_ack && !res_empty) state <= S_SEND;
                S_SEND: if (out_ack) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // data is latched once, stable while req is up
    always_ff @(posedge clk) begin
        if (state == S_IDLE && !out_ack && !res_empty) begin
            out_data <= res_head;
        end
    end

endmodule

`default_nettype wire

// File: src/stream_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module stream_fifo #(
    parameter type         payload_t = logic [7:0],
    parameter int unsigned DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t wdata,
    output logic     full,
    input  logic     pop,
    output payload_t rdata,
    output logic     empty
);

    // DEPTH is a power of two, so pointers wrap on their own
    localparam int unsigned AW = $clog2(DEPTH);

    payload_t mem [0:DEPTH-1];

    // extra msb tells a full buffer from an empty one
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[AW-1:0]] <= wdata;
        end
    end

    // head is read straight from the array
    assign rdata = mem[rd_ptr[AW-1:0]];

    assign empty = (wr_ptr == rd_ptr);
    // same slot, opposite lap
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

endmodule

`default_nettype wire

// File: verif/exec_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module exec_assertions (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       in_req,
    input exec_types_pkg::issue_req_t in_data,
    input logic                       in_ack,
    input logic                       out_req,
    input exec_types_pkg::wb_result_t out_data,
    input logic                       out_ack
);

    // failure counts, read by the testbench at the end of the run
    int unsigned in_hold_fails  = 0;
    int unsigned out_hold_fails = 0;
    int unsigned out_rise_fails = 0;
    int unsigned fail_total;

    assign fail_total = in_hold_fails + out_hold_fails + out_rise_fails;

    // issue data must not move until the decoder has acked it
    in_data_held: assert property (@(posedge clk) disable iff (!rst_n)
        in_req && !in_ack |=> $stable(in_data))
    else begin
        in_hold_fails++;
        $error("in_data changed while in_req was waiting for in_ack");
    end

    // result data is frozen for the whole transfer
    out_data_held: assert property (@(posedge clk) disable iff (!rst_n)
        out_req |=> !out_req || $stable(out_data))
    else begin
        out_hold_fails++;
        $error("out_data changed while out_req was high");
    end

    // the previous ack has to be gone before a new request
    out_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_req) |-> !$past(out_ack))
    else begin
        out_rise_fails++;
        $error("out_req rose while out_ack was still high");
    end

endmodule

`default_nettype wire

// File: verif/tb_exec_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_exec_top;

    import rv32_isa_pkg::*;
    import exec_types_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        in_req;
    issue_req_t  in_data;
    logic        in_ack;
    logic        out_req;
    wb_result_t  out_data;
    logic        out_ack;

    // expected and received results of the running test
    wb_result_t  exp_q[$];
    wb_result_t  got_q[$];

    // receiver behavior, set per test
    int unsigned ack_delay    = 0;
    logic        rand_ack     = 1'b0;
    int unsigned stall_cycles = 0;
    int unsigned ack_wait;

    // separate streams so stimulus and ack timing do not disturb each other
    logic [31:0] stim_lfsr = 32'h8754;
    logic [31:0] ack_lfsr  = 32'h8754;

    logic [3:0]  next_tag    = 4'd0;
    int unsigned err_count   = 0;
    int unsigned err_base    = 0;
    int unsigned tests_run   = 0;
    int unsigned tests_fail  = 0;
    int unsigned cycle_count = 0;
    // enough for reset, raised by each test
    int unsigned cycle_limit = 50;

    exec_top #(
        .OP_DEPTH  (4),
        .RES_DEPTH (4)
    ) dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_req   (in_req),
        .in_data  (in_data),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_data (out_data),
        .out_ack  (out_ack)
    );

    bind exec_top exec_assertions asrt0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_req   (in_req),
        .in_data  (in_data),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_data (out_data),
        .out_ack  (out_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: results still missing after %0d cycles", cycle_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // galois lfsr, right shifting
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'hA300_0000;
        end
        return n;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] draw_bits(inout logic [31:0] state, input int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int unsigned i = 0; i < n; i++) begin
            v = {v[30:0], state[0]};
            state = lfsr_next(state);
        end
        return v;
    endfunction

    // rs1 = x1, rs2 = x2, the values come with the request anyway
    function automatic logic [31:0] r_type_word(
        input logic [2:0] f3,
        input logic       alt,
        input logic [4:0] rd
    );
        return {1'b0, alt, 5'b0, 5'd2, 5'd1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] i_type_word(
        input logic [2:0]  f3,
        input logic [11:0] imm,
        input logic [4:0]  rd
    );
        return {imm, 5'd1, f3, rd, 7'h13};
    endfunction

    function automatic logic [31:0] u_type_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'h37};
    endfunction

    // reference model straight from the RV32I rules
    function automatic wb_result_t predict_result(input issue_req_t req);
        wb_result_t  r;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic        alt;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        opc = req.instr[6:0];
        f3  = req.instr[14:12];
        alt = req.instr[30];
        a   = req.rs1_val;
        // OP-IMM uses the sign-extended I immediate instead of rs2
        b   = (opc == 7'h13) ? {{20{req.instr[31]}}, req.instr[31:20]} : req.rs2_val;
        sh  = b[4:0];
        r.rd      = req.instr[11:7];
        r.tag     = req.tag;
        r.illegal = 1'b0;
        r.value   = '0;
        if (opc == 7'h33 || opc == 7'h13) begin
            case (f3)
                // no SUBI, bit 30 belongs to the immediate
                3'b000: r.value = (opc == 7'h33 && alt) ? a - b : a + b;
                3'b001: r.value = a << sh;
                3'b010: r.value = {31'b0, $signed(a) < $signed(b)};
                3'b011: r.value = {31'b0, a < b};
                3'b100: r.value = a ^ b;
                3'b101: begin
                    if (alt) begin
                        r.value = $signed(a) >>> sh;
                    end else begin
                        r.value = a >> sh;
                    end
                end
                3'b110: r.value = a | b;
                3'b111: r.value = a & b;
            endcase
        end else if (opc == 7'h37) begin
            r.value = {req.instr[31:12], 12'h000};
        end else begin
            r.illegal = 1'b1;
        end
        return r;
    endfunction

    task automatic check_result(input wb_result_t got, input wb_result_t exp);
        if (got.rd !== exp.rd) begin
            $display("mismatch at %0t: out_data.rd got %0d expected %0d", $time, got.rd, exp.rd);
            err_count++;
        end
        if (got.tag !== exp.tag) begin
            $display("mismatch at %0t: out_data.tag got %0d expected %0d",
                     $time, got.tag, exp.tag);
            err_count++;
        end
        if (got.illegal !== exp.illegal) begin
            $display("mismatch at %0t: out_data.illegal got %b expected %b",
                     $time, got.illegal, exp.illegal);
            err_count++;
        end
        if (got.value !== exp.value) begin
            $display("mismatch at %0t: out_data.value got %h expected %h",
                     $time, got.value, exp.value);
            err_count++;
        end
    endtask

    // one four-phase transfer on the issue port, called 1 ns after an edge
    task automatic issue(input logic [31:0] instr, input logic [31:0] rs1, input logic [31:0] rs2);
        issue_req_t req;
        req.instr   = instr;
        req.rs1_val = rs1;
        req.rs2_val = rs2;
        req.tag     = next_tag;
        next_tag    = next_tag + 4'd1;
        exp_q.push_back(predict_result(req));
        in_data = req;
        in_req  = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!in_ack);
        in_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (in_ack);
    endtask

    // receive side, ack timing comes from the test settings
    initial begin : receive_results
        out_ack = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && out_req && !out_ack) begin
                ack_wait = ack_delay;
                if (rand_ack) begin
                    ack_wait = draw_bits(ack_lfsr, 3);
                end
                // the long stall only hits the first result of a test
                ack_wait = ack_wait + ((got_q.size() == 0) ? stall_cycles : 0);
                repeat (ack_wait) begin
                    @(posedge clk);
                    #1;
                end
                out_ack = 1'b1;
                got_q.push_back(out_data);
                do begin
                    @(posedge clk);
                    #1;
                end while (out_req);
                // ack lingers a few cycles after req drops
                ack_wait = ack_delay;
                if (rand_ack) begin
                    ack_wait = draw_bits(ack_lfsr, 2);
                end
                repeat (ack_wait) begin
                    @(posedge clk);
                    #1;
                end
                out_ack = 1'b0;
            end
        end
    end

    task automatic begin_test(
        input int unsigned transfers,
        input int unsigned delay,
        input logic        rand_delay,
        input int unsigned stall
    );
        err_base     = err_count;
        ack_delay    = delay;
        rand_ack     = rand_delay;
        stall_cycles = stall;
        // handshakes on both ports plus the worst ack and release delay per transfer
        cycle_limit  = cycle_count + transfers * (12 + (rand_delay ? 10 : 2 * delay))
                       + stall + 50;
    endtask

    task automatic finish_test(input string name);
        while (got_q.size() < exp_q.size()) begin
            @(posedge clk);
            #1;
        end
        // quiet time, a duplicate result would show up here
        repeat (10) begin
            @(posedge clk);
            #1;
        end
        if (got_q.size() != exp_q.size()) begin
            $display("error at %0t: test %s received %0d results for %0d instructions",
                     $time, name, got_q.size(), exp_q.size());
            err_count++;
        end
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            check_result(got_q[i], exp_q[i]);
        end
        tests_run++;
        if (err_count == err_base) begin
            $display("test %s passed, %0d transfers", name, exp_q.size());
        end else begin
            tests_fail++;
            $display("test %s failed with %0d errors", name, err_count - err_base);
        end
        got_q.delete();
        exp_q.delete();
        stall_cycles = 0;
    endtask

    task automatic reg_ops_test();
        logic [2:0]  f3;
        logic        alt;
        logic [31:0] a;
        logic [31:0] b;
        begin_test(30, 1, 1'b0, 0);
        for (int p = 0; p < 3; p++) begin
            // negative vs positive, small vs large negative, shift above 31
            a = (p == 0) ? 32'hFFFF_FFF0 : (p == 1) ? 32'h0000_0007 : 32'h8765_4321;
            b = (p == 0) ? 32'h0000_0005 : (p == 1) ? 32'h8000_0001 : 32'h0000_0024;
            for (int i = 0; i < 10; i++) begin
                f3  = (i == 8) ? 3'b000 : (i == 9) ? 3'b101 : i[2:0];
                alt = (i >= 8);
                issue(r_type_word(f3, alt, 5'(i + 10 * p)), a, b);
            end
        end
        finish_test("reg_ops");
    endtask

    task automatic imm_ops_test();
        begin_test(10, 0, 1'b0, 0);
        // rs2 carries junk, the immediate must win
        issue(i_type_word(3'b000, 12'hFFB, 5'd1), 32'd100, 32'hDEAD_BEEF);
        issue(i_type_word(3'b010, 12'hFFF, 5'd2), 32'hFFFF_FFFD, 32'hDEAD_BEEF);
        issue(i_type_word(3'b011, 12'hFFF, 5'd3), 32'h0000_0005, 32'hDEAD_BEEF);
        issue(i_type_word(3'b100, 12'h8FF, 5'd4), 32'h0F0F_0F0F, 32'hDEAD_BEEF);
        issue(i_type_word(3'b110, 12'h800, 5'd5), 32'h0000_0000, 32'hDEAD_BEEF);
        issue(i_type_word(3'b111, 12'h7F0, 5'd6), 32'hFFFF_FFFF, 32'hDEAD_BEEF);
        issue(i_type_word(3'b001, {7'h00, 5'd31}, 5'd7), 32'h0000_0001, 32'hDEAD_BEEF);
        issue(i_type_word(3'b101, {7'h00, 5'd7}, 5'd8), 32'h8000_0000, 32'hDEAD_BEEF);
        issue(i_type_word(3'b101, {7'h20, 5'd7}, 5'd9), 32'h8000_0000, 32'hDEAD_BEEF);
        issue(i_type_word(3'b101, {7'h20, 5'd0}, 5'd10), 32'hF000_0001, 32'hDEAD_BEEF);
        finish_test("imm_ops");
    endtask

    task automatic lui_test();
        begin_test(3, 2, 1'b0, 0);
        issue(u_type_word(20'hFFFFF, 5'd31), 32'h1111_1111, 32'h2222_2222);
        issue(u_type_word(20'h12345, 5'd5), 32'h3333_3333, 32'h4444_4444);
        issue(u_type_word(20'h00000, 5'd0), 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        finish_test("lui");
    endtask

    task automatic illegal_test();
        begin_test(7, 1, 1'b0, 0);
        issue(r_type_word(3'b000, 1'b0, 5'd1), 32'd3, 32'd4);
        // load, branch, auipc and an unused opcode
        issue(32'h0000_2083, 32'h1234_5678, 32'h9ABC_DEF0);
        issue(i_type_word(3'b000, 12'h010, 5'd2), 32'd5, 32'd0);
        issue(32'h0020_8063, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        issue(32'h0000_1097, 32'h0000_0001, 32'h0000_0002);
        issue(r_type_word(3'b000, 1'b1, 5'd3), 32'd3, 32'd4);
        issue(32'hFFFF_FFFF, 32'h5555_5555, 32'hAAAA_AAAA);
        finish_test("illegal");
    endtask

    task automatic backpressure_test();
        // 4 op slots, the exec register and 4 result slots fill up
        begin_test(12, 0, 1'b0, 60);
        for (int i = 0; i < 12; i++) begin
            issue(i_type_word(3'b000, 12'(i), 5'(i)), 32'(100 * i), 32'd0);
        end
        finish_test("backpressure");
    endtask

    task automatic random_burst_test();
        logic [31:0] r;
        logic [31:0] instr;
        logic [31:0] op1;
        logic [31:0] op2;
        logic        is_imm;
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  rd;
        begin_test(40, 0, 1'b1, 0);
        for (int n = 0; n < 40; n++) begin
            r      = draw_bits(stim_lfsr, 1);
            is_imm = r[0];
            r      = draw_bits(stim_lfsr, 3);
            f3     = r[2:0];
            r      = draw_bits(stim_lfsr, 1);
            alt    = r[0];
            r      = draw_bits(stim_lfsr, 5);
            rd     = r[4:0];
            if (!is_imm) begin
                // only SUB and SRA use bit 30
                if (f3 != 3'b000 && f3 != 3'b101) begin
                    alt = 1'b0;
                end
                instr = r_type_word(f3, alt, rd);
            end else if (f3 == 3'b001 || f3 == 3'b101) begin
                // shift immediates keep the funct7 form
                r     = draw_bits(stim_lfsr, 5);
                instr = i_type_word(f3, {1'b0, alt & f3[2], 5'b0, r[4:0]}, rd);
            end else begin
                r     = draw_bits(stim_lfsr, 12);
                instr = i_type_word(f3, r[11:0], rd);
            end
            op1 = draw_bits(stim_lfsr, 32);
            op2 = draw_bits(stim_lfsr, 32);
            issue(instr, op1, op2);
        end
        finish_test("random_burst");
    endtask

    initial begin : run_tests
        rst_n   = 1'b0;
        in_req  = 1'b0;
        in_data = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        reg_ops_test();
        imm_ops_test();
        lui_test();
        illegal_test();
        backpressure_test();
        random_burst_test();
        $display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_fail, err_count, dut0.asrt0.fail_total);
        if (err_count == 0 && tests_fail == 0 && dut0.asrt0.fail_total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
